/* source/board_cfg.svh */
// Build-time settings of the board control logic
// Hold lengths are in clk_sys cycles, frame counts in video edges
// BOARD_BUTTONS must stay between 1 and 6

`ifndef BOARD_CFG_SVH
`define BOARD_CFG_SVH

// Game side
`define BOARD_BUTTONS          4
`define BOARD_ACTIVE_LOW       1

// Reset hold-off
`define BOARD_RST_HOLD         16
`define BOARD_GAME_RST_HOLD    32

// Frame based timing
`define BOARD_AUTOFIRE_FRAMES  2
`define BOARD_LED_FRAMES       2

// Special joystick buttons
`define BOARD_JOY_PAUSE_BIT    12
`define BOARD_JOY_RESET_BIT    13

// OSD status word fields
`define BOARD_ST_FLIP          0
`define BOARD_ST_PAUSE         1
`define BOARD_ST_TEST          2
`define BOARD_ST_FX            4
`define BOARD_ST_ROT           6
`define BOARD_ST_AUTOFIRE      18

`endif

/* source/board_pkg.sv */
// Types shared by the board control blocks
// Joystick bit order is right, left, down, up, then buttons 1 to 6

package board_pkg;

    // Board joystick, active high
    // Bits 12 and 13 carry the pause and soft reset buttons
    typedef logic [15:0] board_joy_t;

    // Game joystick in game polarity
    typedef logic [9:0] game_joy_t;

    // One bit per player
    typedef logic [3:0] coin_t;

    // OSD status word as sent by the menu
    typedef logic [63:0] status_t;

    // Sound effect level
    typedef logic [1:0] fxlevel_t;

    // Screen rotation
    typedef logic [1:0] rotate_t;

endpackage

/* source/board_reset_gen.sv */
// Board and game reset generation, all in clk_sys
// pll_locked may be asynchronous, it goes through two flops
// Both resets start high and release after their hold counts

`include "board_cfg.svh"

module board_reset_gen (
    input  logic clk_sys,
    input  logic arst_n,
    input  logic pll_locked,
    input  logic rst_req,
    input  logic downloading,
    input  logic soft_rst,
    output logic rst,
    output logic game_rst
);

    localparam int RW = $clog2(`BOARD_RST_HOLD + 1);
    localparam int GW = $clog2(`BOARD_GAME_RST_HOLD + 1);

    logic [1:0]    lock_sync;
    logic [RW-1:0] rst_cnt;
    logic [GW-1:0] game_cnt;
    logic          rst_nxt;
    logic          game_cause;

    // Next board reset value also feeds the game reset cause,
    // so game_rst rises together with rst
    assign rst_nxt    = !lock_sync[1] || (rst_cnt != RW'(`BOARD_RST_HOLD));
    assign game_cause = rst_nxt | downloading | rst_req | soft_rst;

    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            lock_sync <= 2'b00;
            rst_cnt   <= '0;
            rst       <= 1'b1;
        end else begin
            lock_sync <= {lock_sync[0], pll_locked};
            if (!lock_sync[1]) begin
                rst_cnt <= '0;
            end else if (rst_cnt != RW'(`BOARD_RST_HOLD)) begin
                rst_cnt <= rst_cnt + 1'b1;
            end
            rst <= rst_nxt;
        end
    end

    // Hold restarts whenever any cause comes back
    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            game_cnt <= '0;
            game_rst <= 1'b1;
        end else if (game_cause) begin
            game_cnt <= '0;
            game_rst <= 1'b1;
        end else begin
            if (game_cnt != GW'(`BOARD_GAME_RST_HOLD)) begin
                game_cnt <= game_cnt + 1'b1;
            end
            game_rst <= (game_cnt != GW'(`BOARD_GAME_RST_HOLD));
        end
    end

    // The game must never run while the board is in reset
    a_game_rst_covers_rst: assert property (
        @(posedge clk_sys) disable iff (!arst_n) rst |-> game_rst
    );

endmodule

/* source/board_dip_decode.sv */
// OSD status word to registered DIP controls
// dip_pause and dip_test are active low towards the game
// Only the status bits listed in the config header are decoded

`include "board_cfg.svh"

module board_dip_decode import board_pkg::*; (
    input  logic     clk_sys,
    input  logic     arst_n,
    input  logic     rst,
    input  status_t  status,
    input  logic     osd_shown,
    input  logic     game_pause,
    output logic     dip_flip,
    output logic     dip_pause,
    output logic     dip_test,
    output logic     osd_pause,
    output logic     autofire_en,
    output fxlevel_t dip_fxlevel,
    output rotate_t  rotate
);

    logic osd_pause_nxt;

    // Menu pause only counts while the menu is on screen
    assign osd_pause_nxt = status[`BOARD_ST_PAUSE] & osd_shown;

    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            dip_flip    <= 1'b0;
            dip_pause   <= 1'b1;
            dip_test    <= 1'b1;
            osd_pause   <= 1'b0;
            autofire_en <= 1'b0;
            dip_fxlevel <= '0;
            rotate      <= '0;
        end else if (rst) begin
            dip_flip    <= 1'b0;
            dip_pause   <= 1'b1;
            dip_test    <= 1'b1;
            osd_pause   <= 1'b0;
            autofire_en <= 1'b0;
            dip_fxlevel <= '0;
            rotate      <= '0;
        end else begin
            dip_flip    <= status[`BOARD_ST_FLIP];
            osd_pause   <= osd_pause_nxt;
            // Either pause source stops the game
            dip_pause   <= ~(osd_pause_nxt | game_pause);
            dip_test    <= ~status[`BOARD_ST_TEST];
            autofire_en <= status[`BOARD_ST_AUTOFIRE];
            dip_fxlevel <= status[`BOARD_ST_FX +: 2];
            rotate      <= status[`BOARD_ST_ROT +: 2];
        end
    end

endmodule

/* source/board_input_map.sv */
// Board joysticks, coins and starts to game inputs, one cycle latency
// Buttons above BOARD_BUTTONS always read inactive
// Autofire only acts on button 1 of each player

`include "board_cfg.svh"

module board_input_map import board_pkg::*; (
    input  logic       clk_sys,
    input  logic       arst_n,
    input  logic       rst,
    input  logic       vs,
    input  logic       downloading,
    input  logic       dip_flip,
    input  logic       autofire_en,
    input  board_joy_t board_joystick1,
    input  board_joy_t board_joystick2,
    input  coin_t      board_coin,
    input  coin_t      board_start,
    output game_joy_t  game_joystick1,
    output game_joy_t  game_joystick2,
    output coin_t      game_coin,
    output coin_t      game_start,
    output logic       game_pause,
    output logic       soft_rst
);

    localparam int        AFW      = $clog2(`BOARD_AUTOFIRE_FRAMES + 1);
    localparam game_joy_t BTN_MASK = game_joy_t'((1 << (4 + `BOARD_BUTTONS)) - 1);
    localparam game_joy_t JOY_OFF  = `BOARD_ACTIVE_LOW ? '1 : '0;
    localparam coin_t     COIN_OFF = `BOARD_ACTIVE_LOW ? '1 : '0;

    logic [1:0]          af_held;
    logic [1:0]          af_phase;
    logic [1:0][AFW-1:0] af_cnt;
    logic                vs_l;
    logic                vs_rise;
    logic                pause_l;
    logic                reset_l;

    // Active high game joystick, button 1 replaced by the fire value
    function automatic game_joy_t map_joy(input board_joy_t joy, input logic flip,
                                          input logic fire);
        game_joy_t g;
        g = joy[9:0] & BTN_MASK;
        if (flip) begin
            g[3:0] = {joy[2], joy[3], joy[0], joy[1]};
        end
        g[4] = fire;
        return g;
    endfunction

    assign af_held = {board_joystick2[4], board_joystick1[4]} & {2{autofire_en}};
    assign vs_rise = vs & ~vs_l;

    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            vs_l    <= 1'b0;
            pause_l <= 1'b0;
            reset_l <= 1'b0;
        end else begin
            vs_l    <= vs;
            pause_l <= board_joystick1[`BOARD_JOY_PAUSE_BIT];
            reset_l <= board_joystick1[`BOARD_JOY_RESET_BIT];
        end
    end

    // Phase stays at pressed until the button is held with autofire on
    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            af_phase <= '1;
            af_cnt   <= '0;
        end else begin
            for (int p = 0; p < 2; p++) begin
                if (!af_held[p]) begin
                    af_phase[p] <= 1'b1;
                    af_cnt[p]   <= '0;
                end else if (vs_rise) begin
                    if (af_cnt[p] == AFW'(`BOARD_AUTOFIRE_FRAMES - 1)) begin
                        af_cnt[p]   <= '0;
                        af_phase[p] <= ~af_phase[p];
                    end else begin
                        af_cnt[p] <= af_cnt[p] + 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            game_joystick1 <= JOY_OFF;
            game_joystick2 <= JOY_OFF;
            game_coin      <= COIN_OFF;
            game_start     <= COIN_OFF;
        end else if (rst || downloading) begin
            game_joystick1 <= JOY_OFF;
            game_joystick2 <= JOY_OFF;
            game_coin      <= COIN_OFF;
            game_start     <= COIN_OFF;
        end else begin
            game_joystick1 <= map_joy(board_joystick1, dip_flip,
                                      board_joystick1[4] & af_phase[0]) ^ JOY_OFF;
            game_joystick2 <= map_joy(board_joystick2, dip_flip,
                                      board_joystick2[4] & af_phase[1]) ^ JOY_OFF;
            game_coin      <= board_coin ^ COIN_OFF;
            game_start     <= board_start ^ COIN_OFF;
        end
    end

    // Pause toggles and soft reset pulses on player 1 button edges
    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            game_pause <= 1'b0;
            soft_rst   <= 1'b0;
        end else begin
            soft_rst <= ~rst & board_joystick1[`BOARD_JOY_RESET_BIT] & ~reset_l;
            if (rst) begin
                game_pause <= 1'b0;
            end else if (board_joystick1[`BOARD_JOY_PAUSE_BIT] && !pause_l) begin
                game_pause <= ~game_pause;
            end
        end
    end

    a_soft_rst_pulse: assert property (
        @(posedge clk_sys) disable iff (!arst_n) soft_rst |=> !soft_rst
    );

endmodule

/* source/board_led.sv */
// Status LED, registered
// Blinks during ROM download, counting falling edges of lvbl
// Without video the blink stops, the LED stays put

`include "board_cfg.svh"

module board_led (
    input  logic       clk_sys,
    input  logic       arst_n,
    input  logic       rst,
    input  logic       lvbl,
    input  logic       downloading,
    input  logic       osd_shown,
    input  logic [1:0] game_led,
    output logic       led
);

    localparam int CW = $clog2(`BOARD_LED_FRAMES + 1);

    logic          lvbl_l;
    logic          lvbl_fall;
    logic [CW-1:0] frame_cnt;
    logic [CW-1:0] frame_cnt_nxt;
    logic          blink;
    logic          blink_nxt;

    assign lvbl_fall = ~lvbl & lvbl_l;

    // Blink restarts low at every download
    always_comb begin
        frame_cnt_nxt = frame_cnt;
        blink_nxt     = blink;
        if (!downloading) begin
            frame_cnt_nxt = '0;
            blink_nxt     = 1'b0;
        end else if (lvbl_fall) begin
            if (frame_cnt == CW'(`BOARD_LED_FRAMES - 1)) begin
                frame_cnt_nxt = '0;
                blink_nxt     = ~blink;
            end else begin
                frame_cnt_nxt = frame_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            lvbl_l    <= 1'b0;
            frame_cnt <= '0;
            blink     <= 1'b0;
            led       <= 1'b0;
        end else begin
            lvbl_l    <= lvbl;
            frame_cnt <= frame_cnt_nxt;
            blink     <= blink_nxt;
            if (rst) begin
                led <= 1'b0;
            end else begin
                led <= downloading ? blink_nxt : (osd_shown | game_led[0]);
            end
        end
    end

endmodule

/* source/board_top.sv */
// Control side of the arcade board wrapper
// Single clk_sys domain, arst_n is the only asynchronous input
// Game inputs come out in the polarity set by BOARD_ACTIVE_LOW

module board_top import board_pkg::*; (
    input  logic       clk_sys,
    input  logic       arst_n,
    input  logic       pll_locked,
    input  logic       rst_req,
    input  logic       downloading,
    input  status_t    status,
    input  logic       osd_shown,
    input  logic       vs,
    input  logic       lvbl,
    input  logic [1:0] game_led,
    input  board_joy_t board_joystick1,
    input  board_joy_t board_joystick2,
    input  coin_t      board_coin,
    input  coin_t      board_start,
    output game_joy_t  game_joystick1,
    output game_joy_t  game_joystick2,
    output coin_t      game_coin,
    output coin_t      game_start,
    output logic       rst,
    output logic       game_rst,
    output logic       dip_flip,
    output logic       dip_pause,
    output logic       dip_test,
    output logic       osd_pause,
    output fxlevel_t   dip_fxlevel,
    output rotate_t    rotate,
    output logic       led
);

    logic game_pause;
    logic soft_rst;
    logic autofire_en;

    board_reset_gen u_reset (
        .clk_sys     ( clk_sys     ),
        .arst_n      ( arst_n      ),
        .pll_locked  ( pll_locked  ),
        .rst_req     ( rst_req     ),
        .downloading ( downloading ),
        .soft_rst    ( soft_rst    ),
        .rst         ( rst         ),
        .game_rst    ( game_rst    )
    );

    board_dip_decode u_dip (
        .clk_sys     ( clk_sys     ),
        .arst_n      ( arst_n      ),
        .rst         ( rst         ),
        .status      ( status      ),
        .osd_shown   ( osd_shown   ),
        .game_pause  ( game_pause  ),
        .dip_flip    ( dip_flip    ),
        .dip_pause   ( dip_pause   ),
        .dip_test    ( dip_test    ),
        .osd_pause   ( osd_pause   ),
        .autofire_en ( autofire_en ),
        .dip_fxlevel ( dip_fxlevel ),
        .rotate      ( rotate      )
    );

    board_input_map u_inputs (
        .clk_sys         ( clk_sys         ),
        .arst_n          ( arst_n          ),
        .rst             ( rst             ),
        .vs              ( vs              ),
        .downloading     ( downloading     ),
        .dip_flip        ( dip_flip        ),
        .autofire_en     ( autofire_en     ),
        .board_joystick1 ( board_joystick1 ),
        .board_joystick2 ( board_joystick2 ),
        .board_coin      ( board_coin      ),
        .board_start     ( board_start     ),
        .game_joystick1  ( game_joystick1  ),
        .game_joystick2  ( game_joystick2  ),
        .game_coin       ( game_coin       ),
        .game_start      ( game_start      ),
        .game_pause      ( game_pause      ),
        .soft_rst        ( soft_rst        )
    );

    board_led u_led (
        .clk_sys     ( clk_sys     ),
        .arst_n      ( arst_n      ),
        .rst         ( rst         ),
        .lvbl        ( lvbl        ),
        .downloading ( downloading ),
        .osd_shown   ( osd_shown   ),
        .game_led    ( game_led    ),
        .led         ( led         )
    );

endmodule

/* dv/tb_board.sv */
// Testbench for board_top, driven by the vectors in dv/board_golden.hex
// Each vector holds its inputs for hold cycles, outputs are compared at
// the falling edge before the last held cycle
// A vector with hold 0 ends the list, the file holds at most 64 vectors

module tb_board import board_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int VW      = 9;
    localparam int MAX_VEC = 64;

    logic       clk_sys;
    logic       arst_n;
    logic       pll_locked;
    logic       rst_req;
    logic       downloading;
    status_t    status;
    logic       osd_shown;
    logic       vs;
    logic       lvbl;
    logic [1:0] game_led;
    board_joy_t board_joystick1;
    board_joy_t board_joystick2;
    coin_t      board_coin;
    coin_t      board_start;
    game_joy_t  game_joystick1;
    game_joy_t  game_joystick2;
    coin_t      game_coin;
    coin_t      game_start;
    logic       rst;
    logic       game_rst;
    logic       dip_flip;
    logic       dip_pause;
    logic       dip_test;
    logic       osd_pause;
    fxlevel_t   dip_fxlevel;
    rotate_t    rotate;
    logic       led;

    logic [31:0] vec_mem [MAX_VEC*VW];
    int          vec_count;
    int          hold_total;
    logic        vec_loaded;

    board_top board_top_inst (.*);

    initial begin
        clk_sys = 1'b0;
        forever #50 clk_sys = ~clk_sys;
    end

    task automatic stop_on_error();
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    task automatic check_joy(input string name, input game_joy_t exp, input game_joy_t act);
        if (act !== exp) begin
            $display("Fail at %0t: %s expected %h actual %h", $time, name, exp, act);
            stop_on_error();
        end
    endtask

    task automatic check_coin(input string name, input coin_t exp, input coin_t act);
        if (act !== exp) begin
            $display("Fail at %0t: %s expected %h actual %h", $time, name, exp, act);
            stop_on_error();
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Fail at %0t: %s expected %b actual %b", $time, name, exp, act);
            stop_on_error();
        end
    endtask

    task automatic check_fx(input fxlevel_t exp, input fxlevel_t act);
        if (act !== exp) begin
            $display("Fail at %0t: dip_fxlevel expected %h actual %h", $time, exp, act);
            stop_on_error();
        end
    endtask

    task automatic check_rot(input rotate_t exp, input rotate_t act);
        if (act !== exp) begin
            $display("Fail at %0t: rotate expected %h actual %h", $time, exp, act);
            stop_on_error();
        end
    endtask

    // Word 0 control bits, 1 status low half, 2 and 3 joysticks, 4 start and coin
    task automatic apply_vector(input int v);
        logic [31:0] ctrl;
        logic [31:0] cs;
        ctrl = vec_mem[v*VW];
        cs   = vec_mem[v*VW+4];
        pll_locked      <= ctrl[0];
        rst_req         <= ctrl[1];
        downloading     <= ctrl[2];
        osd_shown       <= ctrl[3];
        vs              <= ctrl[4];
        lvbl            <= ctrl[5];
        game_led        <= ctrl[7:6];
        status          <= {32'h0, vec_mem[v*VW+1]};
        board_joystick1 <= board_joy_t'(vec_mem[v*VW+2]);
        board_joystick2 <= board_joy_t'(vec_mem[v*VW+3]);
        board_coin      <= cs[3:0];
        board_start     <= cs[7:4];
    endtask

    // Mask bit 0 enables the joysticks, bit 1 coins and starts,
    // bits 8 to 18 the matching fields of the expected misc word
    task automatic compare_vector(input int v);
        logic [31:0] ej;
        logic [31:0] em;
        logic [31:0] mask;
        ej   = vec_mem[v*VW+6];
        em   = vec_mem[v*VW+7];
        mask = vec_mem[v*VW+8];
        if (mask[0]) begin
            check_joy("game_joystick1", ej[9:0], game_joystick1);
            check_joy("game_joystick2", ej[19:10], game_joystick2);
        end
        if (mask[1]) begin
            check_coin("game_coin", em[3:0], game_coin);
            check_coin("game_start", em[7:4], game_start);
        end
        if (mask[8])  check_bit("rst", em[8], rst);
        if (mask[9])  check_bit("game_rst", em[9], game_rst);
        if (mask[10]) check_bit("dip_flip", em[10], dip_flip);
        if (mask[11]) check_bit("dip_pause", em[11], dip_pause);
        if (mask[12]) check_bit("dip_test", em[12], dip_test);
        if (mask[13]) check_bit("osd_pause", em[13], osd_pause);
        if (mask[14]) check_fx(em[15:14], dip_fxlevel);
        if (mask[16]) check_rot(em[17:16], rotate);
        if (mask[18]) check_bit("led", em[18], led);
    endtask

    initial begin : watchdog
        longint limit;
        wait (vec_loaded);
        limit = 2 * longint'(hold_total + 2) * 100;
        #(limit);
        $display("watchdog timeout: tests did not finish");
        stop_on_error();
    end

    initial begin : main
        int v;
        arst_n          = 1'b0;
        pll_locked      = 1'b0;
        rst_req         = 1'b0;
        downloading     = 1'b0;
        status          = '0;
        osd_shown       = 1'b0;
        vs              = 1'b0;
        lvbl            = 1'b0;
        game_led        = 2'b00;
        board_joystick1 = '0;
        board_joystick2 = '0;
        board_coin      = '0;
        board_start     = '0;
        vec_loaded      = 1'b0;
        vec_count       = 0;
        hold_total      = 0;
        for (int i = 0; i < MAX_VEC*VW; i++) begin
            vec_mem[i] = '0;
        end
        $readmemh("dv/board_golden.hex", vec_mem);
        while (vec_count < MAX_VEC && vec_mem[vec_count*VW+5] != 0) begin
            hold_total = hold_total + int'(vec_mem[vec_count*VW+5]);
            vec_count++;
        end
        if (vec_count == 0) begin
            $display("golden vector file is empty or could not be read");
            stop_on_error();
        end
        vec_loaded = 1'b1;

        repeat (2) @(posedge clk_sys);
        arst_n <= 1'b1;
        for (v = 0; v < vec_count; v++) begin
            apply_vector(v);
            repeat (int'(vec_mem[v*VW+5]) - 1) @(posedge clk_sys);
            @(negedge clk_sys);
            compare_vector(v);
            @(posedge clk_sys);
        end
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

/* dv/board_golden.hex */
// ctrl status joy1 joy2 start_coin hold exp_joy{j2,j1} exp_misc check_mask
// ctrl: 0 pll, 1 rst_req, 2 downloading, 3 osd_shown, 4 vs, 5 lvbl, 7:6 game_led
// Reset release, rst falls 18 edges after lock, game_rst 32 later
1 0 0 0 0 13 FFFFF 1BFF 7FF03
1 0 0 0 0 1 FFFFF 1AFF 7FF03
1 0 0 0 0 1F FFFFF 1AFF 7FF03
1 0 0 0 0 1 FFFFF 18FF 7FF03
// Joystick mapping, masking, flip, coins and starts
1 0 35 3C0 A5 4 CFFCA 185A 7FF03
1 1 35 3C0 A5 4 CFFC5 1C5A 7FF03
1 0 0 0 0 4 FFFFF 18FF 7FF03
// Pause button toggles
1 0 1000 0 0 4 FFFFF 10FF 7FF03
1 0 0 0 0 4 FFFFF 10FF 7FF03
1 0 1000 0 0 4 FFFFF 18FF 7FF03
1 0 0 0 0 4 FFFFF 18FF 7FF03
// OSD pause, test, fx level, rotation, game LED
9 2 0 0 0 4 FFFFF 430FF 7FF03
1 E4 0 0 0 4 FFFFF 388FF 7FF03
41 0 0 0 0 4 FFFFF 418FF 7FF03
// Soft reset
1 0 2000 0 0 4 FFFFF 1AFF 7FF03
1 0 0 0 0 1F FFFFF 1AFF 7FF03
1 0 0 0 0 1 FFFFF 18FF 7FF03
// Download with LED blink on lvbl falling edges
5 0 35 0 5 4 FFFFF 1AFF 7FF03
25 0 0 0 0 2 FFFFF 1AFF 7FF03
5 0 0 0 0 2 FFFFF 1AFF 7FF03
25 0 0 0 0 2 FFFFF 1AFF 7FF03
5 0 0 0 0 2 FFFFF 41AFF 7FF03
25 0 0 0 0 2 FFFFF 41AFF 7FF03
5 0 0 0 0 2 FFFFF 41AFF 7FF03
25 0 0 0 0 2 FFFFF 41AFF 7FF03
5 0 0 0 0 2 FFFFF 1AFF 7FF03
1 0 0 0 0 22 FFFFF 18FF 7FF03
// Autofire on player 1 button 1
1 40000 0 0 0 4 FFFFF 18FF 7FF03
1 40000 10 0 0 4 FFFEF 18FF 7FF03
11 40000 10 0 0 1 0 0 0
1 40000 10 0 0 2 FFFEF 18FF 7FF03
11 40000 10 0 0 1 0 0 0
1 40000 10 0 0 2 FFFFF 18FF 7FF03
11 40000 10 0 0 1 0 0 0
1 40000 10 0 0 2 FFFFF 18FF 7FF03
11 40000 10 0 0 1 0 0 0
1 40000 10 0 0 2 FFFEF 18FF 7FF03
1 0 0 0 0 4 FFFFF 18FF 7FF03
// End of list
0 0 0 0 0 0 0 0 0

/* sources.f */
+incdir+source
source/board_pkg.sv
source/board_reset_gen.sv
source/board_dip_decode.sv
source/board_input_map.sv
source/board_led.sv
source/board_top.sv
dv/tb_board.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the board testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_board \
    -Mdir build \
    -f sources.f
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "verilator build failed"
    exit $build_status
fi

./build/Vtb_board
sim_status=$?
if [ $sim_status -ne 0 ]; then
    echo "simulation failed"
    exit $sim_status
fi

exit 0
